/* ooo_cfg.svh */
/*
  widths for the execute stage
  data, reorder-buffer tag and shift-count widths
*/

`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// operand and result width
`define OOO_XLEN 32

// reorder-buffer tag width
`define OOO_TAG_W 4

// shift count, taken from the low bits of operand b
`define OOO_SHAMT_W 5

`endif

/* ooo_pkg.sv */
/*
  shared types for the execute stage
  operation codes, CDB packet, operation class helper
*/

`include "ooo_cfg.svh"

package ooo_pkg;

  // operation codes issued by the reservation station
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_sll = 4'd5,
    op_srl = 4'd6,
    op_sra = 4'd7
  } alu_op_t;

  // tagged result broadcast on the CDB
  typedef struct packed {
    logic [`OOO_TAG_W-1:0] dest_rob;
    logic [`OOO_XLEN-1:0]  result;
  } cdb_packet_t;

  // true for operations executed by the shift unit
  function automatic logic is_shift_op(alu_op_t op);
    return (op == op_sll) || (op == op_srl) || (op == op_sra);
  endfunction

endpackage

/* fu_if.sv */
/*
  functional unit interface
  issue handshake from the dispatcher, completion handshake to the arbiter
*/

`timescale 1ns/1ps

`include "ooo_cfg.svh"

interface fu_if;

  // issue side
  logic                  issue_valid;
  logic                  issue_ready;
  ooo_pkg::alu_op_t      op;
  logic [`OOO_XLEN-1:0]  a;
  logic [`OOO_XLEN-1:0]  b;
  logic [`OOO_TAG_W-1:0] tag;

  // completion side, yumi is the one-cycle take pulse
  logic                  done_valid;
  ooo_pkg::cdb_packet_t  packet;
  logic                  yumi;

  modport dispatch (
    output issue_valid, op, a, b, tag,
    input  issue_ready
  );

  modport unit (
    input  issue_valid, op, a, b, tag, yumi,
    output issue_ready, done_valid, packet
  );

  modport arbiter (
    input  done_valid, packet,
    output yumi
  );

endinterface

/* exec_dispatch.sv */
/*
  operation dispatcher
  steers the issue strobe to the alu or shift unit, returns its ready
*/

`timescale 1ns/1ps

`include "ooo_cfg.svh"

module exec_dispatch (
  input  logic                  issue_valid,
  input  ooo_pkg::alu_op_t      issue_op,
  input  logic [`OOO_XLEN-1:0]  issue_a,
  input  logic [`OOO_XLEN-1:0]  issue_b,
  input  logic [`OOO_TAG_W-1:0] issue_tag,
  output logic                  issue_ready,
  fu_if.dispatch                alu_port,
  fu_if.dispatch                shift_port
);

  logic to_shift;

  // operation class decode
  assign to_shift = ooo_pkg::is_shift_op(issue_op);

  // only the selected unit sees the strobe
  assign alu_port.issue_valid   = issue_valid & ~to_shift;
  assign shift_port.issue_valid = issue_valid & to_shift;

  // payload fans out to both units
  assign alu_port.op    = issue_op;
  assign alu_port.a     = issue_a;
  assign alu_port.b     = issue_b;
  assign alu_port.tag   = issue_tag;

  assign shift_port.op  = issue_op;
  assign shift_port.a   = issue_a;
  assign shift_port.b   = issue_b;
  assign shift_port.tag = issue_tag;

  // readiness of the unit the op selects
  assign issue_ready = to_shift ? shift_port.issue_ready : alu_port.issue_ready;

endmodule

/* shift_unit.sv */
/*
  multi-cycle shift unit, one bit per cycle
  operand and count registers with an idle/shift/done controller
*/

`timescale 1ns/1ps

`include "ooo_cfg.svh"

module shift_unit (
  input logic clk,
  input logic reset,
  fu_if.unit  port
);

  typedef enum logic [1:0] {
    s_idle  = 2'b00,
    s_shift = 2'b01,
    s_done  = 2'b10
  } state_t;

  state_t state;
  state_t state_next;

  // datapath registers
  logic [`OOO_XLEN-1:0]    data_q;
  logic [`OOO_SHAMT_W-1:0] count_q;
  logic [`OOO_TAG_W-1:0]   tag_q;
  ooo_pkg::alu_op_t        op_q;

  // controller outputs
  logic                    load;
  logic                    step;
  logic                    count_zero;
  logic [`OOO_XLEN-1:0]    data_step;

  assign count_zero = (count_q == '0);

  assign load = (state == s_idle) & port.issue_valid;
  assign step = (state == s_shift) & ~count_zero;

  // one-bit shift, fill depends on the latched op
  always_comb begin
    case (op_q)
      ooo_pkg::op_sll: data_step = {data_q[`OOO_XLEN-2:0], 1'b0};
      ooo_pkg::op_sra: data_step = {data_q[`OOO_XLEN-1], data_q[`OOO_XLEN-1:1]};
      default:         data_step = {1'b0, data_q[`OOO_XLEN-1:1]};
    endcase
  end

  // operand, count, tag and op
  always_ff @(posedge clk) begin
    if (load) begin
      data_q  <= port.a;
      count_q <= port.b[`OOO_SHAMT_W-1:0];
      tag_q   <= port.tag;
      op_q    <= port.op;
    end else if (step) begin
      data_q  <= data_step;
      count_q <= count_q - 1'b1;
    end
  end

  // state register
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  // next state
  always_comb begin
    state_next = state;
    case (state)
      s_idle: begin
        if (port.issue_valid) begin
          state_next = s_shift;
        end
      end
      s_shift: begin
        // one extra edge once the count has run out
        if (count_zero) begin
          state_next = s_done;
        end
      end
      s_done: begin
        if (port.yumi) begin
          state_next = s_idle;
        end
      end
      default: begin
        state_next = s_idle;
      end
    endcase
  end

  // handshake outputs
  assign port.issue_ready = (state == s_idle);
  assign port.done_valid  = (state == s_done);

  // finished packet, steady while in done
  assign port.packet = '{dest_rob: tag_q, result: data_q};

endmodule

/* alu_unit.sv */
/*
  single-cycle alu unit
  add, sub, and, or, xor with a result holding register
*/

`timescale 1ns/1ps

`include "ooo_cfg.svh"

module alu_unit (
  input logic clk,
  input logic reset,
  fu_if.unit  port
);

  logic                  full;
  logic                  accept;
  logic [`OOO_XLEN-1:0]  alu_result;
  logic [`OOO_XLEN-1:0]  result_q;
  logic [`OOO_TAG_W-1:0] tag_q;

  // accepts only while the holding register is empty
  assign port.issue_ready = ~full;
  assign accept = port.issue_valid & ~full;

  // arithmetic and logic, wraps on overflow
  always_comb begin
    case (port.op)
      ooo_pkg::op_add: alu_result = port.a + port.b;
      ooo_pkg::op_sub: alu_result = port.a - port.b;
      ooo_pkg::op_and: alu_result = port.a & port.b;
      ooo_pkg::op_or:  alu_result = port.a | port.b;
      ooo_pkg::op_xor: alu_result = port.a ^ port.b;
      default:         alu_result = '0;
    endcase
  end

  // full flag, cleared when the arbiter takes the result
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (port.yumi) begin
      full <= 1'b0;
    end
  end

  // holding register
  always_ff @(posedge clk) begin
    if (accept) begin
      result_q <= alu_result;
      tag_q    <= port.tag;
    end
  end

  assign port.done_valid = full;
  assign port.packet     = '{dest_rob: tag_q, result: result_q};

endmodule

/* cdb_arbiter.sv */
/*
  CDB arbiter
  round-robin grant between alu and shift unit, drives the CDB and yumi
*/

`timescale 1ns/1ps

module cdb_arbiter (
  input  logic                  clk,
  input  logic                  reset,
  fu_if.arbiter                 alu_port,
  fu_if.arbiter                 shift_port,
  output logic                  cdb_valid,
  output ooo_pkg::cdb_packet_t  cdb
);

  // set when the shift unit won the last grant
  logic last_shift;
  logic grant_alu;
  logic grant_shift;

  // shift wins when alone, or on a tie when alu won last
  assign grant_shift = shift_port.done_valid & (~alu_port.done_valid | ~last_shift);
  assign grant_alu   = alu_port.done_valid & ~grant_shift;

  assign cdb_valid = alu_port.done_valid | shift_port.done_valid;
  assign cdb       = grant_shift ? shift_port.packet : alu_port.packet;

  // take pulse to the winner
  assign alu_port.yumi   = grant_alu;
  assign shift_port.yumi = grant_shift;

  // reset value favours the alu on the first tie
  always_ff @(posedge clk) begin
    if (reset) begin
      last_shift <= 1'b1;
    end else if (grant_alu | grant_shift) begin
      last_shift <= grant_shift;
    end
  end

endmodule

/* exec_stage.sv */
/*
  execute stage top level
  dispatcher, shift unit, alu unit and CDB arbiter
*/

`timescale 1ns/1ps

`include "ooo_cfg.svh"

module exec_stage (
  input  logic                  clk,
  input  logic                  reset,

  // issue from the reservation station
  input  logic                  issue_valid,
  input  ooo_pkg::alu_op_t      issue_op,
  input  logic [`OOO_XLEN-1:0]  issue_a,
  input  logic [`OOO_XLEN-1:0]  issue_b,
  input  logic [`OOO_TAG_W-1:0] issue_tag,
  output logic                  issue_ready,

  // common data bus
  output logic                  cdb_valid,
  output logic [`OOO_TAG_W-1:0] cdb_tag,
  output logic [`OOO_XLEN-1:0]  cdb_result
);

  ooo_pkg::cdb_packet_t cdb;

  // one bus per functional unit
  fu_if alu_bus ();
  fu_if shift_bus ();

  exec_dispatch u_dispatch (
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_tag   (issue_tag),
    .issue_ready (issue_ready),
    .alu_port    (alu_bus.dispatch),
    .shift_port  (shift_bus.dispatch)
  );

  shift_unit u_shift (
    .clk   (clk),
    .reset (reset),
    .port  (shift_bus.unit)
  );

  alu_unit u_alu (
    .clk   (clk),
    .reset (reset),
    .port  (alu_bus.unit)
  );

  cdb_arbiter u_arbiter (
    .clk        (clk),
    .reset      (reset),
    .alu_port   (alu_bus.arbiter),
    .shift_port (shift_bus.arbiter),
    .cdb_valid  (cdb_valid),
    .cdb        (cdb)
  );

  // split the broadcast packet
  assign cdb_tag    = cdb.dest_rob;
  assign cdb_result = cdb.result;

endmodule

/* exec_stage_chk.sv */
/*
  concurrent assertions for the execute stage
  quiet CDB after reset, known issue_ready, shift unit busy
*/

`timescale 1ns/1ps

`include "ooo_cfg.svh"

module exec_stage_chk (
  input logic                  clk,
  input logic                  reset,
  input logic                  issue_valid,
  input ooo_pkg::alu_op_t      issue_op,
  input logic [`OOO_TAG_W-1:0] issue_tag,
  input logic                  issue_ready,
  input logic                  cdb_valid,
  input logic [`OOO_TAG_W-1:0] cdb_tag
);

  int                    failures;
  logic                  shift_accept;
  logic                  shift_busy;
  logic [`OOO_TAG_W-1:0] shift_tag;

  initial begin
    failures = 0;
  end

  assign shift_accept = issue_valid & issue_ready & ooo_pkg::is_shift_op(issue_op);

  // shift in flight until its tag is broadcast
  always_ff @(posedge clk) begin
    if (reset) begin
      shift_busy <= 1'b0;
    end else if (shift_accept) begin
      shift_busy <= 1'b1;
      shift_tag  <= issue_tag;
    end else if (cdb_valid && cdb_tag == shift_tag) begin
      shift_busy <= 1'b0;
    end
  end

  a_quiet_after_reset: assert property (@(posedge clk) reset |=> !cdb_valid)
    else begin
      failures = failures + 1;
      $error("cdb_valid high in the cycle after reset");
    end

  a_ready_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(issue_ready))
    else begin
      failures = failures + 1;
      $error("issue_ready is unknown");
    end

  a_shift_busy: assert property (@(posedge clk) disable iff (reset)
    shift_busy && ooo_pkg::is_shift_op(issue_op) |-> !issue_ready)
    else begin
      failures = failures + 1;
      $error("shift unit ready while a shift is in flight");
    end

endmodule

bind exec_stage exec_stage_chk u_chk (
  .clk         (clk),
  .reset       (reset),
  .issue_valid (issue_valid),
  .issue_op    (issue_op),
  .issue_tag   (issue_tag),
  .issue_ready (issue_ready),
  .cdb_valid   (cdb_valid),
  .cdb_tag     (cdb_tag)
);

/* exec_stage_tb.sv */
/*
  testbench for the execute stage
  clock, LFSR stimulus, reference model, tag scoreboard, watchdog, report
*/

`timescale 1ns/1ps

`include "ooo_cfg.svh"

module exec_stage_tb;

  localparam int n_tags = 1 << `OOO_TAG_W;
  // shift 24, alu 20, out of order 16, back-pressure 8, arbitration 16
  localparam int total_ops = 84;
  // longest shift plus arbitration, with room to spare
  localparam int drain_cycles = 80;

  logic                  clk;
  logic                  reset;
  logic                  issue_valid;
  ooo_pkg::alu_op_t      issue_op;
  logic [`OOO_XLEN-1:0]  issue_a;
  logic [`OOO_XLEN-1:0]  issue_b;
  logic [`OOO_TAG_W-1:0] issue_tag;
  logic                  issue_ready;
  logic                  cdb_valid;
  logic [`OOO_TAG_W-1:0] cdb_tag;
  logic [`OOO_XLEN-1:0]  cdb_result;

  logic [15:0]           lfsr;
  ooo_pkg::cdb_packet_t  expected [n_tags];
  ooo_pkg::cdb_packet_t  seen;
  logic [n_tags-1:0]     in_flight;
  int                    next_tag;
  int                    issued;
  int                    errors;
  int                    tests_run;
  int                    tests_failed;
  int                    issued_at;
  int                    errors_at;
  string                 cur_test;

  exec_stage DUT (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_tag   (issue_tag),
    .issue_ready (issue_ready),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_result  (cdb_result)
  );

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // expected packet from the operation rules
  function automatic ooo_pkg::cdb_packet_t model_packet(
    input ooo_pkg::alu_op_t      op,
    input logic [`OOO_XLEN-1:0]  a,
    input logic [`OOO_XLEN-1:0]  b,
    input logic [`OOO_TAG_W-1:0] tag
  );
    ooo_pkg::cdb_packet_t p;
    int                   amt;
    amt = b[`OOO_SHAMT_W-1:0];
    p.dest_rob = tag;
    if (ooo_pkg::is_shift_op(op)) begin
      case (op)
        ooo_pkg::op_sll: p.result = a << amt;
        ooo_pkg::op_srl: p.result = a >> amt;
        default:         p.result = $signed(a) >>> amt;
      endcase
    end else begin
      case (op)
        ooo_pkg::op_add: p.result = a + b;
        ooo_pkg::op_sub: p.result = a - b;
        ooo_pkg::op_and: p.result = a & b;
        ooo_pkg::op_or:  p.result = a | b;
        default:         p.result = a ^ b;
      endcase
    end
    return p;
  endfunction

  task automatic check_packet(input string name, input ooo_pkg::cdb_packet_t exp,
                              input ooo_pkg::cdb_packet_t act);
    if (act !== exp) begin
      errors++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  // CDB monitor against the tag scoreboard
  always @(posedge clk) begin
    if (!reset && cdb_valid === 1'b1) begin
      if (!in_flight[cdb_tag]) begin
        errors++;
        $display("%s: tag %0d came on the CDB but was not in flight", cur_test, cdb_tag);
      end else begin
        seen.dest_rob = cdb_tag;
        seen.result   = cdb_result;
        check_packet(cur_test, expected[cdb_tag], seen);
        in_flight[cdb_tag] = 1'b0;
      end
    end
  end

  // picks a free tag, holds valid until the edge that sees ready
  task automatic issue(input ooo_pkg::alu_op_t op, input logic [`OOO_XLEN-1:0] a,
                       input logic [`OOO_XLEN-1:0] b);
    int   tag;
    logic taken;
    tag = -1;
    while (tag < 0) begin
      @(negedge clk);
      for (int i = 0; i < n_tags; i++) begin
        if (tag < 0 && !in_flight[(next_tag + i) % n_tags]) begin
          tag = (next_tag + i) % n_tags;
        end
      end
    end
    next_tag = (tag + 1) % n_tags;
    issue_valid = 1'b1;
    issue_op    = op;
    issue_a     = a;
    issue_b     = b;
    issue_tag   = tag[`OOO_TAG_W-1:0];
    expected[tag]  = model_packet(op, a, b, issue_tag);
    in_flight[tag] = 1'b1;
    issued++;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = (issue_ready === 1'b1);
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    issued_at = issued;
    errors_at = errors;
  endtask

  // drain all tags, then one line for the test
  task automatic end_test();
    int waited;
    @(negedge clk);
    issue_valid = 1'b0;
    waited = 0;
    while (in_flight != '0 && waited < drain_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (in_flight != '0) begin
      errors++;
      $display("%s: %0d operations never came on the CDB", cur_test,
               $countones(in_flight));
      in_flight = '0;
    end
    tests_run++;
    if (errors != errors_at) begin
      tests_failed++;
    end
    $display("%s: %0d operations, %0d errors", cur_test, issued - issued_at,
             errors - errors_at);
  endtask

  task automatic reset_test();
    start_test("reset");
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      check_flag("reset cdb_valid", 1'b0, cdb_valid);
    end
    // ready follows the op presented, both units idle
    @(negedge clk);
    issue_op = ooo_pkg::op_sll;
    @(posedge clk);
    check_flag("reset shift ready", 1'b1, issue_ready);
    @(negedge clk);
    issue_op = ooo_pkg::op_add;
    @(posedge clk);
    check_flag("reset alu ready", 1'b1, issue_ready);
    end_test();
  endtask

  task automatic shift_test();
    logic [`OOO_XLEN-1:0] a;
    logic [`OOO_XLEN-1:0] b;
    start_test("shift");
    for (int i = 0; i < 24; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      // amounts 0 and 31 for each kind first
      if (i < 3) begin
        b[`OOO_SHAMT_W-1:0] = '0;
      end else if (i < 6) begin
        b[`OOO_SHAMT_W-1:0] = '1;
      end
      issue(ooo_pkg::alu_op_t'(5 + i % 3), a, b);
    end
    end_test();
  endtask

  task automatic alu_test();
    logic [`OOO_XLEN-1:0] a;
    logic [`OOO_XLEN-1:0] b;
    logic [31:0]          sel;
    start_test("alu");
    for (int i = 0; i < 20; i++) begin
      sel = rand_bits(3);
      a   = rand_bits(32);
      b   = rand_bits(32);
      issue(ooo_pkg::alu_op_t'(sel % 5), a, b);
    end
    end_test();
  endtask

  task automatic out_of_order_test();
    logic [`OOO_XLEN-1:0] b;
    logic [31:0]          sel;
    start_test("out of order");
    for (int r = 0; r < 4; r++) begin
      b   = rand_bits(32);
      sel = rand_bits(2);
      b[`OOO_SHAMT_W-1:0] = '1;
      issue(ooo_pkg::alu_op_t'(5 + sel % 3), rand_bits(32), b);
      // alu ops finish before the long shift
      for (int i = 0; i < 3; i++) begin
        sel = rand_bits(3);
        issue(ooo_pkg::alu_op_t'(sel % 5), rand_bits(32), rand_bits(32));
      end
    end
    end_test();
  endtask

  task automatic back_pressure_test();
    logic [`OOO_XLEN-1:0] b;
    logic [31:0]          sel;
    start_test("back-pressure");
    for (int r = 0; r < 4; r++) begin
      b   = rand_bits(32);
      sel = rand_bits(3);
      b[`OOO_SHAMT_W-1:0] = 5'd20 + sel[`OOO_SHAMT_W-1:0];
      issue(ooo_pkg::op_sra, rand_bits(32), b);
      issue(ooo_pkg::op_sll, rand_bits(32), rand_bits(32));
    end
    end_test();
  endtask

  task automatic arbitration_test();
    logic [`OOO_XLEN-1:0] b;
    start_test("arbitration");
    for (int r = 0; r < 8; r++) begin
      // zero-amount shift then alu, both done after the same edge
      b = rand_bits(32);
      b[`OOO_SHAMT_W-1:0] = '0;
      issue(ooo_pkg::op_srl, rand_bits(32), b);
      issue(ooo_pkg::op_sub, rand_bits(32), rand_bits(32));
    end
    end_test();
  endtask

  initial begin
    lfsr         = 16'd19293;
    reset        = 1'b1;
    issue_valid  = 1'b0;
    issue_op     = ooo_pkg::op_add;
    issue_a      = '0;
    issue_b      = '0;
    issue_tag    = '0;
    in_flight    = '0;
    next_tag     = 0;
    issued       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = "reset";
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_test();
    shift_test();
    alu_test();
    out_of_order_test();
    back_pressure_test();
    arbitration_test();
    $display("%0d tests, %0d failed, %0d errors, %0d assertion failures", tests_run,
             tests_failed, errors, DUT.u_chk.failures);
    if (errors == 0 && DUT.u_chk.failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog, 40 cycles of 20 ns per operation plus margin
  initial begin
    #(total_ops * 40 * 20 + 5000);
    $display("watchdog: the run did not finish in time, stopping");
    $display("Test failed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
ooo_pkg.sv
fu_if.sv
exec_dispatch.sv
shift_unit.sv
alu_unit.sv
cdb_arbiter.sv
exec_stage.sv
exec_stage_chk.sv
exec_stage_tb.sv
